//--- rtl/axi_pkg.sv
package axi_pkg;

    // byte address on the AR and AW channels
    typedef logic [31:0] axi_addr_t;

    // one 64-bit beat on R and W
    typedef logic [63:0] axi_data_t;

    // one strobe bit per data byte
    typedef logic [7:0]  axi_strb_t;

    // burst length minus one
    typedef logic [7:0]  axi_len_t;

    // log2 of the bytes per beat
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;

    // incrementing burst, the only type issued here
    localparam axi_burst_t AXI_BURST_INCR = 2'b01;
    localparam axi_resp_t  AXI_RESP_OKAY  = 2'b00;

    // 8 bytes per beat
    localparam axi_size_t  AXI_SIZE_8B    = 3'd3;

endpackage

//--- rtl/mem_pkg.sv
package mem_pkg;

    // words per cache line
    localparam int LINE_BEATS       = 4;
    // byte offset inside a 32-byte line
    localparam int LINE_OFFSET_BITS = 5;
    // byte offset inside a 64-bit word
    localparam int WORD_OFFSET_BITS = 3;

    typedef logic [31:0] paddr_t;
    typedef logic [63:0] word_t;
    typedef logic [7:0]  wmask_t;

    // beat 0 sits in the low 64 bits
    typedef logic [LINE_BEATS*64-1:0] line_t;

    // request kinds seen by the bridge
    typedef enum logic {
        REQ_READ_LINE,
        REQ_WRITE_WORD
    } req_kind_t;

endpackage

//--- rtl/axi_if.sv
interface axi_if;

    // write address channel
    logic                   aw_valid;
    logic                   aw_ready;
    axi_pkg::axi_addr_t     aw_addr;

    // write data channel, single beat only
    logic                   w_valid;
    logic                   w_ready;
    axi_pkg::axi_data_t     w_data;
    axi_pkg::axi_strb_t     w_strb;
    logic                   w_last;

    // write response
    logic                   b_valid;
    logic                   b_ready;
    axi_pkg::axi_resp_t     b_resp;

    // read address channel
    logic                   ar_valid;
    logic                   ar_ready;
    axi_pkg::axi_addr_t     ar_addr;
    axi_pkg::axi_len_t      ar_len;
    axi_pkg::axi_size_t     ar_size;
    axi_pkg::axi_burst_t    ar_burst;

    // read data channel
    logic                   r_valid;
    logic                   r_ready;
    axi_pkg::axi_data_t     r_data;
    axi_pkg::axi_resp_t     r_resp;
    logic                   r_last;

    // bridge side
    modport master (
        output aw_valid, aw_addr,
        input  aw_ready,
        output w_valid, w_data, w_strb, w_last,
        input  w_ready,
        input  b_valid, b_resp,
        output b_ready,
        output ar_valid, ar_addr, ar_len, ar_size, ar_burst,
        input  ar_ready,
        input  r_valid, r_data, r_resp, r_last,
        output r_ready
    );

    // memory side
    modport slave (
        input  aw_valid, aw_addr,
        output aw_ready,
        input  w_valid, w_data, w_strb, w_last,
        output w_ready,
        output b_valid, b_resp,
        input  b_ready,
        input  ar_valid, ar_addr, ar_len, ar_size, ar_burst,
        output ar_ready,
        output r_valid, r_data, r_resp, r_last,
        input  r_ready
    );

endinterface

//--- rtl/mem_req_if.sv
interface mem_req_if;

    // request, held by the arbiter until ready
    logic                   valid;
    logic                   ready;
    mem_pkg::req_kind_t     kind;
    mem_pkg::paddr_t        addr;
    mem_pkg::word_t         wdata;
    mem_pkg::wmask_t        wmask;

    // one-cycle completion and the read line
    logic                   done;
    mem_pkg::line_t         line;

    modport arb (
        output valid, kind, addr, wdata, wmask,
        input  ready, done, line
    );

    modport bridge (
        input  valid, kind, addr, wdata, wmask,
        output ready, done, line
    );

endinterface

//--- rtl/mem_port_arb.sv
module mem_port_arb (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  logic                rf_valid_i,
    input  mem_pkg::paddr_t     rf_addr_i,
    output logic                rf_ready_o,
    output logic                rf_done_o,
    output mem_pkg::line_t      rf_line_o,

    input  logic                wr_valid_i,
    input  mem_pkg::paddr_t     wr_addr_i,
    input  mem_pkg::word_t      wr_data_i,
    input  mem_pkg::wmask_t     wr_mask_i,
    output logic                wr_ready_o,
    output logic                wr_done_o,

    mem_req_if.arb              req
);

    // clears the byte offset inside a line
    localparam mem_pkg::paddr_t LINE_MASK =
        ~((mem_pkg::paddr_t'(1) << mem_pkg::LINE_OFFSET_BITS) - mem_pkg::paddr_t'(1));

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_READ,
        ARB_WRITE
    } arb_state_t;

    arb_state_t state_q;
    logic       idle_s;
    logic       accept_s;

    assign idle_s   = (state_q == ARB_IDLE);
    assign accept_s = req.valid & req.ready;

    // forward in the same cycle, write port wins
    assign req.valid = idle_s & (rf_valid_i | wr_valid_i);
    assign req.kind  = wr_valid_i ? mem_pkg::REQ_WRITE_WORD : mem_pkg::REQ_READ_LINE;
    assign req.addr  = wr_valid_i ? wr_addr_i : (rf_addr_i & LINE_MASK);
    assign req.wdata = wr_data_i;
    assign req.wmask = wr_mask_i;

    // refill blocked while a write is pending
    assign wr_ready_o = idle_s & req.ready;
    assign rf_ready_o = idle_s & req.ready & ~wr_valid_i;

    // completion goes back to the owner only
    assign rf_done_o = (state_q == ARB_READ) & req.done;
    assign wr_done_o = (state_q == ARB_WRITE) & req.done;
    assign rf_line_o = req.line;

    // grant locked from accept until done
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ARB_IDLE;
        end else begin
            unique case (state_q)
                ARB_IDLE: begin
                    if (accept_s) begin
                        state_q <= wr_valid_i ? ARB_WRITE : ARB_READ;
                    end
                end
                ARB_READ, ARB_WRITE: begin
                    if (req.done) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/axi_rw.sv
module axi_rw (
    input  logic        clk_i,
    input  logic        rst_n_i,
    mem_req_if.bridge   req,
    axi_if.master       axi
);

    localparam int WORD_W    = $bits(mem_pkg::word_t);
    localparam int BEAT_BITS = $clog2(mem_pkg::LINE_BEATS);

    typedef enum logic [2:0] {
        RW_IDLE,
        RW_AR,
        RW_R,
        RW_AWW,
        RW_B,
        RW_DONE
    } rw_state_t;

    rw_state_t              state_q;
    rw_state_t              state_d;

    // registered request
    mem_pkg::paddr_t        addr_q;
    mem_pkg::word_t         wdata_q;
    mem_pkg::wmask_t        wmask_q;
    mem_pkg::line_t         line_q;

    // beat slot for the next R beat
    logic [BEAT_BITS-1:0]   beat_q;
    // AW and W may finish in either order
    logic                   aw_done_q;
    logic                   w_done_q;

    logic                   accept_s;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   r_hs;
    logic                   b_hs;

    assign accept_s = req.valid & req.ready;
    assign aw_hs    = axi.aw_valid & axi.aw_ready;
    assign w_hs     = axi.w_valid & axi.w_ready;
    assign r_hs     = axi.r_valid & axi.r_ready;
    assign b_hs     = axi.b_valid & axi.b_ready;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            RW_IDLE: begin
                if (accept_s) begin
                    state_d = (req.kind == mem_pkg::REQ_READ_LINE) ? RW_AR : RW_AWW;
                end
            end
            RW_AR: begin
                if (axi.ar_ready) begin
                    state_d = RW_R;
                end
            end
            // leave once the last beat is in
            RW_R: begin
                if (r_hs && axi.r_last) begin
                    state_d = RW_DONE;
                end
            end
            RW_AWW: begin
                if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
                    state_d = RW_B;
                end
            end
            RW_B: begin
                if (b_hs) begin
                    state_d = RW_DONE;
                end
            end
            RW_DONE: state_d = RW_IDLE;
            default: state_d = RW_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= RW_IDLE;
            beat_q    <= '0;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept_s) begin
                beat_q    <= '0;
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
            end else begin
                if (r_hs) begin
                    beat_q <= beat_q + 1'b1;
                end
                if (aw_hs) begin
                    aw_done_q <= 1'b1;
                end
                if (w_hs) begin
                    w_done_q <= 1'b1;
                end
            end
        end
    end

    // request payload and line assembly
    always_ff @(posedge clk_i) begin
        if (accept_s) begin
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
            wmask_q <= req.wmask;
        end
        if (r_hs) begin
            line_q[beat_q*WORD_W +: WORD_W] <= axi.r_data;
        end
    end

    assign req.ready = (state_q == RW_IDLE);
    assign req.done  = (state_q == RW_DONE);
    assign req.line  = line_q;

    // full line as one INCR burst
    assign axi.ar_valid = (state_q == RW_AR);
    assign axi.ar_addr  = axi_pkg::axi_addr_t'(addr_q);
    assign axi.ar_len   = axi_pkg::axi_len_t'(mem_pkg::LINE_BEATS - 1);
    assign axi.ar_size  = axi_pkg::AXI_SIZE_8B;
    assign axi.ar_burst = axi_pkg::AXI_BURST_INCR;
    assign axi.r_ready  = (state_q == RW_R);

    // single beat write, valids drop after their handshake
    assign axi.aw_valid = (state_q == RW_AWW) & ~aw_done_q;
    assign axi.aw_addr  = axi_pkg::axi_addr_t'(addr_q);
    assign axi.w_valid  = (state_q == RW_AWW) & ~w_done_q;
    assign axi.w_data   = wdata_q;
    assign axi.w_strb   = wmask_q;
    assign axi.w_last   = 1'b1;
    assign axi.b_ready  = (state_q == RW_B);

endmodule

//--- rtl/axi_slave_mem.sv
module axi_slave_mem #(
    parameter int MEM_WORDS = 1024
) (
    input  logic    clk_i,
    input  logic    rst_n_i,
    axi_if.slave    axi
);

    localparam int IDX_BITS = $clog2(MEM_WORDS);

    typedef logic [IDX_BITS-1:0] idx_t;

    typedef enum logic {
        SR_IDLE,
        SR_BURST
    } sr_state_t;

    typedef enum logic {
        SW_TAKE,
        SW_RESP
    } sw_state_t;

    // word array, zero from the start
    axi_pkg::axi_data_t mem [MEM_WORDS] = '{default: '0};

    sr_state_t          rstate_q;
    idx_t               raddr_q;
    axi_pkg::axi_len_t  left_q;
    logic               incr_q;

    sw_state_t          wstate_q;
    logic               aw_got_q;
    logic               w_got_q;
    idx_t               aw_idx_q;
    axi_pkg::axi_data_t wdata_q;
    axi_pkg::axi_strb_t wstrb_q;

    logic               ar_hs;
    logic               r_hs;
    logic               aw_hs;
    logic               w_hs;
    logic               mem_we;
    idx_t               wr_idx;
    axi_pkg::axi_data_t wr_data;
    axi_pkg::axi_strb_t wr_strb;

    // byte address to word index, wraps at the array size
    function automatic idx_t word_idx(input axi_pkg::axi_addr_t addr);
        return idx_t'((addr >> mem_pkg::WORD_OFFSET_BITS) % MEM_WORDS);
    endfunction

    assign ar_hs = axi.ar_valid & axi.ar_ready;
    assign r_hs  = axi.r_valid & axi.r_ready;
    assign aw_hs = axi.aw_valid & axi.aw_ready;
    assign w_hs  = axi.w_valid & axi.w_ready;

    // read side
    assign axi.ar_ready = (rstate_q == SR_IDLE);
    assign axi.r_valid  = (rstate_q == SR_BURST);
    assign axi.r_data   = mem[raddr_q];
    assign axi.r_resp   = axi_pkg::AXI_RESP_OKAY;
    assign axi.r_last   = axi.r_valid & (left_q == '0);

    // beat stays put while r_ready is low
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rstate_q <= SR_IDLE;
            raddr_q  <= '0;
            left_q   <= '0;
            incr_q   <= 1'b0;
        end else begin
            unique case (rstate_q)
                SR_IDLE: begin
                    if (ar_hs) begin
                        rstate_q <= SR_BURST;
                        raddr_q  <= word_idx(axi.ar_addr);
                        left_q   <= axi.ar_len;
                        incr_q   <= (axi.ar_burst == axi_pkg::AXI_BURST_INCR);
                    end
                end
                SR_BURST: begin
                    if (r_hs) begin
                        if (left_q == '0) begin
                            rstate_q <= SR_IDLE;
                        end else begin
                            left_q <= left_q - 1'b1;
                            // fixed bursts keep the same word
                            if (incr_q) begin
                                raddr_q <= (raddr_q == idx_t'(MEM_WORDS - 1)) ?
                                           '0 : raddr_q + 1'b1;
                            end
                        end
                    end
                end
                default: rstate_q <= SR_IDLE;
            endcase
        end
    end

    // write side, AW and W in any order
    assign axi.aw_ready = (wstate_q == SW_TAKE) & ~aw_got_q;
    assign axi.w_ready  = (wstate_q == SW_TAKE) & ~w_got_q;
    assign axi.b_valid  = (wstate_q == SW_RESP);
    assign axi.b_resp   = axi_pkg::AXI_RESP_OKAY;

    // take whichever half arrives now, the other from its latch
    assign wr_idx  = aw_got_q ? aw_idx_q : word_idx(axi.aw_addr);
    assign wr_data = w_got_q ? wdata_q : axi.w_data;
    assign wr_strb = w_got_q ? wstrb_q : axi.w_strb;
    assign mem_we  = (aw_got_q | aw_hs) & (w_got_q | w_hs);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wstate_q <= SW_TAKE;
            aw_got_q <= 1'b0;
            w_got_q  <= 1'b0;
        end else begin
            unique case (wstate_q)
                SW_TAKE: begin
                    if (mem_we) begin
                        wstate_q <= SW_RESP;
                        aw_got_q <= 1'b0;
                        w_got_q  <= 1'b0;
                    end else begin
                        if (aw_hs) begin
                            aw_got_q <= 1'b1;
                        end
                        if (w_hs) begin
                            w_got_q <= 1'b1;
                        end
                    end
                end
                // b_valid held until the master takes it
                SW_RESP: begin
                    if (axi.b_ready) begin
                        wstate_q <= SW_TAKE;
                    end
                end
                default: wstate_q <= SW_TAKE;
            endcase
        end
    end

    // latched halves of a split write
    always_ff @(posedge clk_i) begin
        if (aw_hs) begin
            aw_idx_q <= word_idx(axi.aw_addr);
        end
        if (w_hs) begin
            wdata_q <= axi.w_data;
            wstrb_q <= axi.w_strb;
        end
    end

    // strobed byte update
    always_ff @(posedge clk_i) begin
        if (mem_we) begin
            for (int b = 0; b < $bits(axi_pkg::axi_strb_t); b++) begin
                if (wr_strb[b]) begin
                    mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- rtl/mem_subsys_top.sv
module mem_subsys_top #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // refill port
    input  logic                rf_valid_i,
    input  mem_pkg::paddr_t     rf_addr_i,
    output logic                rf_ready_o,
    output logic                rf_done_o,
    output mem_pkg::line_t      rf_line_o,

    // write port
    input  logic                wr_valid_i,
    input  mem_pkg::paddr_t     wr_addr_i,
    input  mem_pkg::word_t      wr_data_i,
    input  mem_pkg::wmask_t     wr_mask_i,
    output logic                wr_ready_o,
    output logic                wr_done_o
);

    // arbiter to bridge
    mem_req_if req_bus ();

    // bridge to memory slave
    axi_if axi_bus ();

    mem_port_arb u_mem_port_arb (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rf_valid_i (rf_valid_i),
        .rf_addr_i  (rf_addr_i),
        .rf_ready_o (rf_ready_o),
        .rf_done_o  (rf_done_o),
        .rf_line_o  (rf_line_o),
        .wr_valid_i (wr_valid_i),
        .wr_addr_i  (wr_addr_i),
        .wr_data_i  (wr_data_i),
        .wr_mask_i  (wr_mask_i),
        .wr_ready_o (wr_ready_o),
        .wr_done_o  (wr_done_o),
        .req        (req_bus.arb)
    );

    axi_rw u_axi_rw (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req        (req_bus.bridge),
        .axi        (axi_bus.master)
    );

    // depth passed down from the top
    axi_slave_mem #(
        .MEM_WORDS  (MEM_WORDS)
    ) u_axi_slave_mem (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .axi        (axi_bus.slave)
    );

endmodule

//--- bench/tb_mem_subsys.sv
module tb_mem_subsys;

    localparam int MEM_WORDS = 1024;
    localparam int N_RANDOM  = 200;
    // directed operations on top of the random ones
    localparam int N_OPS     = N_RANDOM + 16;
    localparam int OP_BOUND  = 40;
    // cycles a port waits for ready or done
    localparam int WAIT_MAX  = 40;

    logic               clk_i;
    logic               rst_n_i;
    logic               rf_valid_i;
    mem_pkg::paddr_t    rf_addr_i;
    logic               rf_ready_o;
    logic               rf_done_o;
    mem_pkg::line_t     rf_line_o;
    logic               wr_valid_i;
    mem_pkg::paddr_t    wr_addr_i;
    mem_pkg::word_t     wr_data_i;
    mem_pkg::wmask_t    wr_mask_i;
    logic               wr_ready_o;
    logic               wr_done_o;

    // reference memory
    mem_pkg::word_t     ref_mem [MEM_WORDS];

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int rf_sent      = 0;
    int wr_sent      = 0;
    int rf_seen      = 0;
    int wr_seen      = 0;
    int cycle        = 0;

    mem_subsys_top #(
        .MEM_WORDS  (MEM_WORDS)
    ) u_mem_subsys_top (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rf_valid_i (rf_valid_i),
        .rf_addr_i  (rf_addr_i),
        .rf_ready_o (rf_ready_o),
        .rf_done_o  (rf_done_o),
        .rf_line_o  (rf_line_o),
        .wr_valid_i (wr_valid_i),
        .wr_addr_i  (wr_addr_i),
        .wr_data_i  (wr_data_i),
        .wr_mask_i  (wr_mask_i),
        .wr_ready_o (wr_ready_o),
        .wr_done_o  (wr_done_o)
    );

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    // every done pulse counted once at mid-cycle
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (rf_done_o) begin
                rf_seen <= rf_seen + 1;
            end
            if (wr_done_o) begin
                wr_seen <= wr_seen + 1;
            end
        end
    end

    task automatic check(input string name, input logic [255:0] actual,
                         input logic [255:0] expected);
        if (actual !== expected) begin
            $display("** Error %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    // masked bytes of one word
    function automatic void update_ref(input mem_pkg::paddr_t addr,
                                       input mem_pkg::word_t data,
                                       input mem_pkg::wmask_t mask);
        int idx;
        idx = int'(addr >> 3) % MEM_WORDS;
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) begin
                ref_mem[idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endfunction

    // four words of the aligned line with word 0 low
    function automatic mem_pkg::line_t expected_line(input mem_pkg::paddr_t addr);
        int             base;
        mem_pkg::line_t line;
        base = (int'(addr >> 5) * 4) % MEM_WORDS;
        for (int i = 0; i < 4; i++) begin
            line[i*64 +: 64] = ref_mem[(base + i) % MEM_WORDS];
        end
        return line;
    endfunction

    task automatic write_word(input mem_pkg::paddr_t addr, input mem_pkg::word_t data,
                              input mem_pkg::wmask_t mask, output int done_cyc);
        int waited;
        bit taken;
        bit seen;
        done_cyc = -1;
        taken    = 1'b0;
        seen     = 1'b0;
        waited   = 0;
        @(posedge clk_i);
        wr_valid_i <= 1'b1;
        wr_addr_i  <= addr;
        wr_data_i  <= data;
        wr_mask_i  <= mask;
        // ready seen mid-cycle means taken on the next edge
        while (!taken && waited < WAIT_MAX) begin
            @(negedge clk_i);
            taken = wr_ready_o;
            waited++;
        end
        @(posedge clk_i);
        wr_valid_i <= 1'b0;
        if (!taken) begin
            $display("write to %h was never accepted", addr);
            errors++;
            return;
        end
        wr_sent++;
        waited = 0;
        while (!seen && waited < WAIT_MAX) begin
            @(negedge clk_i);
            check("wr_ready_o", wr_ready_o, 1'b0);
            seen = wr_done_o;
            waited++;
        end
        if (!seen) begin
            $display("write to %h never returned wr_done_o", addr);
            errors++;
            return;
        end
        done_cyc = cycle;
        update_ref(addr, data, mask);
    endtask

    task automatic refill_line(input mem_pkg::paddr_t addr, output mem_pkg::line_t line,
                               output int done_cyc);
        int waited;
        bit taken;
        bit seen;
        done_cyc = -1;
        line     = '0;
        taken    = 1'b0;
        seen     = 1'b0;
        waited   = 0;
        @(posedge clk_i);
        rf_valid_i <= 1'b1;
        rf_addr_i  <= addr;
        while (!taken && waited < WAIT_MAX) begin
            @(negedge clk_i);
            taken = rf_ready_o;
            waited++;
        end
        @(posedge clk_i);
        rf_valid_i <= 1'b0;
        if (!taken) begin
            $display("refill of %h was never accepted", addr);
            errors++;
            return;
        end
        rf_sent++;
        waited = 0;
        while (!seen && waited < WAIT_MAX) begin
            @(negedge clk_i);
            check("rf_ready_o", rf_ready_o, 1'b0);
            seen = rf_done_o;
            waited++;
        end
        if (!seen) begin
            $display("refill of %h never returned rf_done_o", addr);
            errors++;
            return;
        end
        // line only valid with done
        line     = rf_line_o;
        done_cyc = cycle;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - err_before);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    // bound per operation covers gaps and the slowest refill
    initial begin
        repeat (10 + N_OPS * OP_BOUND + 100) @(posedge clk_i);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

    initial begin
        mem_pkg::paddr_t    addr;
        mem_pkg::paddr_t    addr2;
        mem_pkg::word_t     data;
        mem_pkg::wmask_t    mask;
        mem_pkg::line_t     got;
        mem_pkg::line_t     got2;
        int                 wr_cyc;
        int                 rf_cyc;
        int                 err0;
        rst_n_i    = 1'b0;
        rf_valid_i = 1'b0;
        rf_addr_i  = '0;
        wr_valid_i = 1'b0;
        wr_addr_i  = '0;
        wr_data_i  = '0;
        wr_mask_i  = '0;
        void'($urandom(32'hbcce));
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // idle outputs and then a blank memory
        err0 = errors;
        @(negedge clk_i);
        check("rf_done_o", rf_done_o, 1'b0);
        check("wr_done_o", wr_done_o, 1'b0);
        check("rf_ready_o", rf_ready_o, 1'b1);
        check("wr_ready_o", wr_ready_o, 1'b1);
        for (int i = 0; i < 4; i++) begin
            addr = $urandom & 32'h1fff;
            refill_line(addr, got, rf_cyc);
            check("rf_line_o", got, '0);
        end
        report_test("reset state", err0);

        // one word written under a mask
        err0 = errors;
        addr = $urandom & 32'h1ff8;
        data = {$urandom, $urandom};
        mask = mem_pkg::wmask_t'($urandom) | 8'h01;
        write_word(addr, data, mask, wr_cyc);
        refill_line(addr, got, rf_cyc);
        check("rf_line_o", got, expected_line(addr));
        report_test("masked write", err0);

        // offset inside the line ignored
        err0 = errors;
        addr  = $urandom & 32'h1fe0;
        addr2 = addr | mem_pkg::paddr_t'($urandom_range(31, 1));
        write_word(addr | 32'h8, {$urandom, $urandom}, 8'hff, wr_cyc);
        refill_line(addr, got, rf_cyc);
        refill_line(addr2, got2, rf_cyc);
        check("rf_line_o", got, expected_line(addr));
        check("rf_line_o", got2, expected_line(addr2));
        report_test("unaligned refill", err0);

        // both ports in one cycle with the write going first
        err0 = errors;
        addr = $urandom & 32'h1ff8;
        data = {$urandom, $urandom};
        mask = mem_pkg::wmask_t'($urandom) | 8'h80;
        fork
            write_word(addr, data, mask, wr_cyc);
            refill_line(addr, got, rf_cyc);
        join
        check("wr_done_o before rf_done_o", wr_cyc < rf_cyc, 1'b1);
        check("rf_line_o", got, expected_line(addr));
        report_test("same cycle requests", err0);

        // mixed traffic with idle gaps
        err0 = errors;
        for (int n = 0; n < N_RANDOM; n++) begin
            repeat ($urandom_range(3, 0)) @(posedge clk_i);
            addr = $urandom & 32'h1fff;
            if ($urandom_range(1, 0) == 1) begin
                data = {$urandom, $urandom};
                mask = mem_pkg::wmask_t'($urandom);
                write_word(addr & 32'h1ff8, data, mask, wr_cyc);
            end else begin
                refill_line(addr, got, rf_cyc);
                check("rf_line_o", got, expected_line(addr));
            end
        end
        // let the last count settle
        repeat (2) @(posedge clk_i);
        check("rf_done_o count", rf_seen, rf_sent);
        check("wr_done_o count", wr_seen, wr_sent);
        report_test("random traffic", err0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/axi_pkg.sv
rtl/mem_pkg.sv
rtl/axi_if.sv
rtl/mem_req_if.sv
rtl/mem_port_arb.sv
rtl/axi_rw.sv
rtl/axi_slave_mem.sv
rtl/mem_subsys_top.sv
bench/tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f \
    --top-module tb_mem_subsys --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Regression passed"; then
    exit 0
fi
exit 1
